// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_rv_core
FILELIST   := project.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing -j 0 -Wno-fatal
PASS_TEXT  := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: project.f
verilog/rv_pkg.sv
verilog/rv_main_control.sv
verilog/rv_reg_file.sv
verilog/rv_imm_gen.sv
verilog/rv_alu.sv
verilog/rv_pc_unit.sv
verilog/rv_core.sv
verif/rv_checker.sv
verif/tb_rv_core.sv

// File: verif/rv_checker.sv
`timescale 1ns/1ns
`default_nettype none

module rv_checker #(
	parameter rv_pkg::word_t PC_RESET = rv_pkg::PC_RESET_DEFAULT,
	parameter int PROG_LEN = 128,
	parameter int DM_DEPTH = 256
) (
	input wire                i_clk,
	input wire                i_rst,
	input wire rv_pkg::word_t i_im_addr,
	input wire rv_pkg::word_t i_dm_addr,
	input wire rv_pkg::word_t i_dm_wdata,
	input wire                i_dm_wen,
	input wire                i_dm_ren
);

	localparam int PA_MSB = $clog2(PROG_LEN) + 1;
	localparam int DA_MSB = $clog2(DM_DEPTH) + 1;

	logic [31:0] prog_mem [0:PROG_LEN-1];
	logic [31:0] data_mem [0:DM_DEPTH-1];
	logic [31:0] xreg [0:31];
	logic [31:0] pc;
	string       test_name;
	bit          armed;
	bit          lost;
	int          errors;

	task automatic set_instr(input int idx, input logic [31:0] word);
		prog_mem[idx] = word;
	endtask

	task automatic set_data(input int idx, input logic [31:0] word);
		data_mem[idx] = word;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors = 0;
		lost = 1'b0;
		pc = PC_RESET;
		xreg[0] = 32'd0;
		armed = 1'b1;
	endtask

	task automatic end_test(output bit ok);
		armed = 1'b0;
		ok = (errors == 0);
		if (ok) begin
			$display("Test %s: pass", test_name);
		end else begin
			$display("Test %s: fail with %0d errors", test_name, errors);
		end
	endtask

	task automatic report_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		$display("Error %s: %s expected %h actual %h", test_name, what, exp, act);
		errors++;
	endtask

	task automatic report_text(input string msg);
		$display("Test %s: %s at PC %h", test_name, msg, pc);
		errors++;
	endtask

	// RV32I semantics for the kept ALU instructions
	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100:  return a ^ b;
			3'b110:  return a | b;
			3'b111:  return a & b;
			default: return 32'd0;
		endcase
	endfunction

	function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000:  return a == b;
			3'b001:  return a != b;
			3'b100:  return $signed(a) < $signed(b);
			3'b101:  return $signed(a) >= $signed(b);
			default: return 1'b0;
		endcase
	endfunction

	task automatic step_model();
		logic [31:0] off;
		logic [31:0] instr;
		logic [31:0] rs1v;
		logic [31:0] rs2v;
		logic [31:0] imm_i;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] next_pc;
		logic [6:0]  op;
		logic        wr;
		off = pc - PC_RESET;
		instr = prog_mem[off[PA_MSB:2]];
		if (i_im_addr !== pc) begin
			report_value("fetch address", pc, i_im_addr);
			lost = 1'b1;
			return;
		end
		op = instr[6:0];
		rs1v = xreg[instr[19:15]];
		rs2v = xreg[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		next_pc = pc + 32'd4;
		res = 32'd0;
		addr = 32'd0;
		wr = 1'b0;
		case (op)
			rv_pkg::OP_RTYPE: begin
				res = alu_model(instr[14:12], instr[30], rs1v, rs2v);
				wr = 1'b1;
			end
			rv_pkg::OP_ITYPE: begin
				res = alu_model(instr[14:12], 1'b0, rs1v, imm_i);
				wr = 1'b1;
			end
			rv_pkg::OP_LUI: begin
				res = {instr[31:12], 12'h000};
				wr = 1'b1;
			end
			rv_pkg::OP_LOAD: begin
				addr = rs1v + imm_i;
				res = data_mem[addr[DA_MSB:2]];
				wr = 1'b1;
			end
			rv_pkg::OP_STORE: begin
				addr = rs1v + {{20{instr[31]}}, instr[31:25], instr[11:7]};
				data_mem[addr[DA_MSB:2]] = rs2v;
			end
			rv_pkg::OP_BRANCH: begin
				if (branch_taken(instr[14:12], rs1v, rs2v)) begin
					next_pc = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
				end
			end
			rv_pkg::OP_JAL: begin
				res = pc + 32'd4;
				wr = 1'b1;
				next_pc = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			rv_pkg::OP_JALR: begin
				res = pc + 32'd4;
				wr = 1'b1;
				next_pc = (rs1v + imm_i) & ~32'd1;
			end
			default: begin
			end
		endcase
		// Store strobe and payload
		if (op == rv_pkg::OP_STORE) begin
			if (i_dm_wen !== 1'b1) begin
				report_text("no store strobe for an SW");
			end else begin
				if (i_dm_addr !== addr) begin
					report_value("store address", addr, i_dm_addr);
				end
				if (i_dm_wdata !== rs2v) begin
					report_value("store data", rs2v, i_dm_wdata);
				end
			end
		end else if (i_dm_wen !== 1'b0) begin
			report_text("store strobe without an SW");
		end
		if (i_dm_ren !== (op == rv_pkg::OP_LOAD)) begin
			report_text("read strobe does not match the instruction");
		end
		if (wr && instr[11:7] != 5'd0) begin
			xreg[instr[11:7]] = res;
		end
		pc = next_pc;
	endtask

	// Mid-cycle sampling, away from the clock edge
	always @(negedge i_clk) begin
		if (armed && !i_rst) begin
			if (i_im_addr !== PC_RESET) begin
				report_value("fetch address in reset", PC_RESET, i_im_addr);
			end
			if (i_dm_wen !== 1'b0 || i_dm_ren !== 1'b0) begin
				report_text("memory strobe active during reset");
			end
		end else if (armed && !lost) begin
			step_model();
		end
	end

endmodule

`default_nettype wire

// File: verif/tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

	localparam rv_pkg::word_t PC_RESET = rv_pkg::PC_RESET_DEFAULT;
	localparam int PROG_LEN = 128;
	localparam int DM_DEPTH = 256;
	localparam int BODY_START = 31;
	localparam int DUMP_START = PROG_LEN - 32;
	localparam logic [11:0] DUMP_BYTE = 12'h200;
	localparam rv_pkg::word_t HALT_ADDR = PC_RESET + 32'(4 * (PROG_LEN - 1));
	localparam int TIMEOUT = 4 * PROG_LEN;
	localparam int DRIVE_DLY = 1;

	logic          clk;
	logic          rst;
	rv_pkg::word_t im_addr;
	rv_pkg::word_t im_off;
	rv_pkg::word_t im_instr;
	rv_pkg::word_t dm_addr;
	rv_pkg::word_t dm_wdata;
	rv_pkg::word_t dm_rdata;
	logic          dm_wen;
	logic          dm_ren;
	logic [31:0]   prog [0:PROG_LEN-1];
	logic [31:0]   dmem [0:DM_DEPTH-1];
	int            tests_run;
	int            tests_failed;

	always #4 clk = ~clk;

	rv_core #(
		.PC_RESET (PC_RESET)
	) dut (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_im_instr (im_instr),
		.i_dm_rdata (dm_rdata),
		.o_im_addr  (im_addr),
		.o_dm_addr  (dm_addr),
		.o_dm_wdata (dm_wdata),
		.o_dm_wen   (dm_wen),
		.o_dm_ren   (dm_ren)
	);

	rv_checker #(
		.PC_RESET (PC_RESET),
		.PROG_LEN (PROG_LEN),
		.DM_DEPTH (DM_DEPTH)
	) u_checker (
		.i_clk      (clk),
		.i_rst      (rst),
		.i_im_addr  (im_addr),
		.i_dm_addr  (dm_addr),
		.i_dm_wdata (dm_wdata),
		.i_dm_wen   (dm_wen),
		.i_dm_ren   (dm_ren)
	);

	// Combinational instruction and data ports
	assign im_off   = im_addr - PC_RESET;
	assign im_instr = prog[im_off[8:2]];
	assign dm_rdata = dmem[dm_addr[9:2]];

	always @(posedge clk) begin
		if (dm_wen) begin
			dmem[dm_addr[9:2]] = dm_wdata;
		end
	end

	function automatic logic [31:0] fill_word(input int idx);
		logic [31:0] a;
		a = 32'(idx);
		return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
	endfunction

	// funct3 for ADD, SUB, AND, OR, XOR and SLT selectors
	function automatic logic [2:0] alu_f3(input logic [2:0] sel);
		case (sel)
			3'd0, 3'd1: return 3'b000;
			3'd2:       return 3'b111;
			3'd3:       return 3'b110;
			3'd4:       return 3'b100;
			default:    return 3'b010;
		endcase
	endfunction

	// 0 R, 1 I, 2 LUI, 3 LW, 4 SW, 5 branch, 6 JAL, 7 JALR
	function automatic int pick_kind(input int mode);
		int r;
		r = int'($urandom % 8);
		case (mode)
			1:       return r % 2;
			2:       return (r < 6) ? 3 + r % 2 : 1;
			3:       return (r < 6) ? 5 + r % 3 : 1;
			5:       return (r < 4) ? 2 : 1;
			default: return r;
		endcase
	endfunction

	function automatic logic [4:0] pick_rd(input int mode);
		logic [31:0] r;
		r = $urandom;
		if (r[2:0] == 3'd0 || (mode == 4 && r[3])) begin
			return 5'd0;
		end
		return r[8:4];
	endfunction

	task automatic gen_program(input int mode);
		int          idx;
		int          kind;
		int          tgt;
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] mimm;
		logic [12:0] boff;
		logic [20:0] joff;
		bit          target_hit [0:PROG_LEN-1];
		for (idx = 0; idx < PROG_LEN; idx++) begin
			target_hit[idx] = 1'b0;
		end
		// Prologue gives every register a known value
		for (idx = 0; idx < BODY_START; idx++) begin
			r = $urandom;
			prog[idx] = {r[11:0], 5'd0, 3'b000, 5'(idx + 1), rv_pkg::OP_ITYPE};
		end
		idx = BODY_START;
		while (idx < DUMP_START) begin
			kind = pick_kind(mode);
			r = $urandom;
			rd = pick_rd(mode);
			rs1 = r[12:8];
			rs2 = r[17:13];
			mimm = {4'd0, r[7:2], 2'b00};
			tgt = idx + 1 + int'(r[31:29]);
			// A JALR that is a jump target would run without its ADDI
			if (kind == 7 && (idx + 1 >= DUMP_START || target_hit[idx + 1])) begin
				kind = 1;
			end
			if (tgt > DUMP_START) begin
				tgt = DUMP_START;
			end
			boff = 13'(4 * (tgt - idx));
			joff = 21'(4 * (tgt - idx));
			case (kind)
				0: prog[idx] = {(r[2:0] == 3'd1) ? 7'h20 : 7'h00, rs2, rs1,
					alu_f3(r[2:0]), rd, rv_pkg::OP_RTYPE};
				1: prog[idx] = {r[31:20], rs1, alu_f3(r[2:0]), rd, rv_pkg::OP_ITYPE};
				2: prog[idx] = {r[31:12], rd, rv_pkg::OP_LUI};
				3: prog[idx] = {mimm, 5'd0, 3'b010, rd, rv_pkg::OP_LOAD};
				4: prog[idx] = {mimm[11:5], rs2, 5'd0, 3'b010, mimm[4:0], rv_pkg::OP_STORE};
				5: prog[idx] = {boff[12], boff[10:5], rs2, rs1, r[1], 1'b0, r[0],
					boff[4:1], boff[11], rv_pkg::OP_BRANCH};
				6: prog[idx] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, rv_pkg::OP_JAL};
				default: begin
					// ADDI sets up the target, JALR offset 1 exercises the bit 0 clear
					if (rs1 == 5'd0) begin
						rs1 = 5'd1;
					end
					if (tgt < DUMP_START) begin
						tgt = tgt + 1;
					end
					prog[idx] = {12'(PC_RESET + 32'(4 * tgt)), 5'd0, 3'b000, rs1, rv_pkg::OP_ITYPE};
					idx = idx + 1;
					prog[idx] = {11'd0, r[0], rs1, 3'b000, rd, rv_pkg::OP_JALR};
				end
			endcase
			if (kind >= 5) begin
				target_hit[tgt] = 1'b1;
			end
			idx = idx + 1;
		end
		// Register dump, then JAL x0 to itself
		for (idx = 1; idx < 32; idx++) begin
			mimm = DUMP_BYTE + 12'(4 * idx);
			prog[DUMP_START + idx - 1] = {mimm[11:5], 5'(idx), 5'd0, 3'b010, mimm[4:0],
				rv_pkg::OP_STORE};
		end
		prog[PROG_LEN-1] = {20'd0, 5'd0, rv_pkg::OP_JAL};
	endtask

	task automatic run_test(input string name, input int mode);
		int cyc;
		bit done;
		bit ok;
		@(posedge clk);
		#DRIVE_DLY rst = 1'b0;
		@(posedge clk);
		#DRIVE_DLY;
		gen_program(mode);
		for (int i = 0; i < PROG_LEN; i++) begin
			u_checker.set_instr(i, prog[i]);
		end
		for (int i = 0; i < DM_DEPTH; i++) begin
			dmem[i] = fill_word(i);
			u_checker.set_data(i, dmem[i]);
		end
		u_checker.start_test(name);
		repeat (3) @(posedge clk);
		#DRIVE_DLY rst = 1'b1;
		done = 1'b0;
		for (cyc = 0; cyc < TIMEOUT && !done; cyc++) begin
			@(posedge clk);
			#DRIVE_DLY;
			if (im_addr == HALT_ADDR) begin
				done = 1'b1;
			end
		end
		if (!done) begin
			$display("Test %s never reached the halt address within %0d cycles", name, TIMEOUT);
			$display("SOME TESTS FAILED");
			$finish;
		end else begin
			// One more cycle so the halt fetch is compared too
			@(posedge clk);
			#DRIVE_DLY;
			u_checker.end_test(ok);
			tests_run++;
			if (!ok) begin
				tests_failed++;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < PROG_LEN; i++) begin
			prog[i] = 32'd0;
		end
		for (int i = 0; i < DM_DEPTH; i++) begin
			dmem[i] = 32'd0;
		end
		void'($urandom(32'h7563));
		run_test("alu_ops", 1);
		run_test("load_store", 2);
		run_test("branch_jump", 3);
		run_test("x0_writes", 4);
		run_test("lui_imm", 5);
		run_test("mixed", 0);
		$display("Tests run: %0d, passed: %0d, failed: %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none

module rv_alu (
	input  wire rv_pkg::word_t   i_a,
	input  wire rv_pkg::word_t   i_b,
	input  wire rv_pkg::alu_op_t i_op,
	output rv_pkg::word_t        o_res,
	output logic                 o_zero,
	output logic                 o_lt
);

	logic lt_signed;

	assign lt_signed = $signed(i_a) < $signed(i_b);

	always_comb begin
		case (i_op)
			rv_pkg::ALU_ADD:   o_res = i_a + i_b;
			rv_pkg::ALU_SUB:   o_res = i_a - i_b;
			rv_pkg::ALU_AND:   o_res = i_a & i_b;
			rv_pkg::ALU_OR:    o_res = i_a | i_b;
			rv_pkg::ALU_XOR:   o_res = i_a ^ i_b;
			rv_pkg::ALU_SLT:   o_res = {31'd0, lt_signed};
			rv_pkg::ALU_PASSB: o_res = i_b;
			default:           o_res = '0;
		endcase
	end

	// Flags for the branch decision, zero means equal under SUB
	assign o_zero = (o_res == '0);
	assign o_lt   = lt_signed;

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
	parameter rv_pkg::word_t PC_RESET = rv_pkg::PC_RESET_DEFAULT
) (
	input  wire                i_clk,
	input  wire                i_rst,
	input  wire rv_pkg::word_t i_im_instr,
	input  wire rv_pkg::word_t i_dm_rdata,
	output rv_pkg::word_t      o_im_addr,
	output rv_pkg::word_t      o_dm_addr,
	output rv_pkg::word_t      o_dm_wdata,
	output logic               o_dm_wen,
	output logic               o_dm_ren
);

	// Control lines
	rv_pkg::alu_op_t alu_op;
	logic [1:0]      src_a;
	logic            src_b;
	logic            reg_write;
	logic            mem_read;
	logic            mem_write;
	logic            mem_to_reg;
	logic            branch;
	logic            link;
	rv_pkg::jump_t   jump;

	// Datapath
	rv_pkg::word_t pc;
	rv_pkg::word_t pc_plus4;
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;
	rv_pkg::word_t imm;
	rv_pkg::word_t alu_a;
	rv_pkg::word_t alu_b;
	rv_pkg::word_t alu_res;
	rv_pkg::word_t wb_data;
	logic          zero;
	logic          lt;

	rv_main_control u_control (
		.i_instr      (i_im_instr),
		.o_alu_op     (alu_op),
		.o_src_a      (src_a),
		.o_src_b      (src_b),
		.o_reg_write  (reg_write),
		.o_mem_read   (mem_read),
		.o_mem_write  (mem_write),
		.o_mem_to_reg (mem_to_reg),
		.o_branch     (branch),
		.o_link       (link),
		.o_jump       (jump)
	);

	rv_reg_file u_reg_file (
		.i_clk    (i_clk),
		.i_rs1    (i_im_instr[19:15]),
		.i_rs2    (i_im_instr[24:20]),
		.i_rd     (i_im_instr[11:7]),
		.i_wen    (reg_write),
		.i_wdata  (wb_data),
		.o_rdata1 (rs1_data),
		.o_rdata2 (rs2_data)
	);

	rv_imm_gen u_imm_gen (
		.i_instr (i_im_instr),
		.o_imm   (imm)
	);

	// Operand A is rs1, PC or zero
	assign alu_a = src_a[1] ? '0 : (src_a[0] ? pc : rs1_data);
	assign alu_b = src_b ? imm : rs2_data;

	rv_alu u_alu (
		.i_a    (alu_a),
		.i_b    (alu_b),
		.i_op   (alu_op),
		.o_res  (alu_res),
		.o_zero (zero),
		.o_lt   (lt)
	);

	rv_pc_unit #(
		.PC_RESET (PC_RESET)
	) u_pc_unit (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_branch   (branch),
		.i_f3       (i_im_instr[14:12]),
		.i_zero     (zero),
		.i_lt       (lt),
		.i_jump     (jump),
		.i_imm      (imm),
		.i_alu_res  (alu_res),
		.o_pc       (pc),
		.o_pc_plus4 (pc_plus4)
	);

	// Write back, link address wins over load data
	assign wb_data = link ? pc_plus4 : (mem_to_reg ? i_dm_rdata : alu_res);

	assign o_im_addr  = pc;
	assign o_dm_addr  = alu_res;
	assign o_dm_wdata = rs2_data;
	assign o_dm_wen   = mem_write;
	assign o_dm_ren   = mem_read;

endmodule

`default_nettype wire

// File: verilog/rv_imm_gen.sv
`timescale 1ns/1ns
`default_nettype none

module rv_imm_gen (
	input  wire rv_pkg::word_t i_instr,
	output rv_pkg::word_t      o_imm
);

	logic sign;

	assign sign = i_instr[31];

	// Format follows the opcode, B and J come out as byte offsets
	always_comb begin
		case (i_instr[6:0])
			rv_pkg::OP_ITYPE, rv_pkg::OP_LOAD, rv_pkg::OP_JALR:
				o_imm = {{20{sign}}, i_instr[31:20]};
			rv_pkg::OP_STORE:
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			rv_pkg::OP_BRANCH:
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
			rv_pkg::OP_JAL:
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
			rv_pkg::OP_LUI:
				o_imm = {i_instr[31:12], 12'h000};
			default:
				o_imm = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/rv_main_control.sv
`timescale 1ns/1ns
`default_nettype none

module rv_main_control (
	input  wire rv_pkg::word_t   i_instr,
	output rv_pkg::alu_op_t      o_alu_op,
	output logic [1:0]           o_src_a,
	output logic                 o_src_b,
	output logic                 o_reg_write,
	output logic                 o_mem_read,
	output logic                 o_mem_write,
	output logic                 o_mem_to_reg,
	output logic                 o_branch,
	output logic                 o_link,
	output rv_pkg::jump_t        o_jump
);

	logic [6:0] opcode;
	logic [2:0] f3;
	logic       f7_alt;
	rv_pkg::alu_op_t arith_op;

	assign opcode = i_instr[6:0];
	assign f3     = i_instr[14:12];
	assign f7_alt = i_instr[30];

	// funct3 to ALU op, SUB only exists in R-type
	always_comb begin
		case (f3)
			3'b000: arith_op = (opcode == rv_pkg::OP_RTYPE && f7_alt) ?
				rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
			3'b010: arith_op = rv_pkg::ALU_SLT;
			3'b100: arith_op = rv_pkg::ALU_XOR;
			3'b110: arith_op = rv_pkg::ALU_OR;
			3'b111: arith_op = rv_pkg::ALU_AND;
			default: arith_op = rv_pkg::ALU_ADD;
		endcase
	end

	always_comb begin
		// Defaults give a plain PC+4 with no side effects
		o_alu_op     = rv_pkg::ALU_ADD;
		o_src_a      = 2'b00;
		o_src_b      = 1'b0;
		o_reg_write  = 1'b0;
		o_mem_read   = 1'b0;
		o_mem_write  = 1'b0;
		o_mem_to_reg = 1'b0;
		o_branch     = 1'b0;
		o_link       = 1'b0;
		o_jump       = rv_pkg::JMP_NONE;
		case (opcode)
			rv_pkg::OP_RTYPE: begin
				o_alu_op    = arith_op;
				o_reg_write = 1'b1;
			end
			rv_pkg::OP_ITYPE: begin
				o_alu_op    = arith_op;
				o_src_b     = 1'b1;
				o_reg_write = 1'b1;
			end
			rv_pkg::OP_LOAD: begin
				o_src_b      = 1'b1;
				o_reg_write  = 1'b1;
				o_mem_read   = 1'b1;
				o_mem_to_reg = 1'b1;
			end
			rv_pkg::OP_STORE: begin
				o_src_b     = 1'b1;
				o_mem_write = 1'b1;
			end
			rv_pkg::OP_BRANCH: begin
				// Compare rs1 against rs2 for the flags
				o_alu_op = rv_pkg::ALU_SUB;
				o_branch = 1'b1;
			end
			rv_pkg::OP_JAL: begin
				o_src_a     = 2'b01;
				o_src_b     = 1'b1;
				o_reg_write = 1'b1;
				o_link      = 1'b1;
				o_jump      = rv_pkg::JMP_JAL;
			end
			rv_pkg::OP_JALR: begin
				o_src_b     = 1'b1;
				o_reg_write = 1'b1;
				o_link      = 1'b1;
				o_jump      = rv_pkg::JMP_JALR;
			end
			rv_pkg::OP_LUI: begin
				o_alu_op    = rv_pkg::ALU_PASSB;
				o_src_a     = 2'b10;
				o_src_b     = 1'b1;
				o_reg_write = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/rv_pc_unit.sv
`timescale 1ns/1ns
`default_nettype none

module rv_pc_unit #(
	parameter rv_pkg::word_t PC_RESET = rv_pkg::PC_RESET_DEFAULT
) (
	input  wire                i_clk,
	input  wire                i_rst,
	input  wire                i_branch,
	input  wire [2:0]          i_f3,
	input  wire                i_zero,
	input  wire                i_lt,
	input  wire rv_pkg::jump_t i_jump,
	input  wire rv_pkg::word_t i_imm,
	input  wire rv_pkg::word_t i_alu_res,
	output rv_pkg::word_t      o_pc,
	output rv_pkg::word_t      o_pc_plus4
);

	rv_pkg::word_t pc;
	rv_pkg::word_t pc_next;
	logic          cond_met;

	// BEQ, BNE, BLT, BGE
	always_comb begin
		case (i_f3)
			3'b000:  cond_met = i_zero;
			3'b001:  cond_met = !i_zero;
			3'b100:  cond_met = i_lt;
			3'b101:  cond_met = !i_lt;
			default: cond_met = 1'b0;
		endcase
	end

	assign o_pc_plus4 = pc + 32'd4;

	always_comb begin
		if (i_jump == rv_pkg::JMP_JALR) begin
			pc_next = {i_alu_res[31:1], 1'b0};
		end else if (i_jump == rv_pkg::JMP_JAL || (i_branch && cond_met)) begin
			pc_next = pc + i_imm;
		end else begin
			pc_next = o_pc_plus4;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			pc <= PC_RESET;
		end else begin
			pc <= pc_next;
		end
	end

	assign o_pc = pc;

endmodule

`default_nettype wire

// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [3:0] alu_op_t;
	typedef logic [1:0] jump_t;

	// ALU operations
	localparam alu_op_t ALU_ADD   = 4'd0;
	localparam alu_op_t ALU_SUB   = 4'd1;
	localparam alu_op_t ALU_AND   = 4'd2;
	localparam alu_op_t ALU_OR    = 4'd3;
	localparam alu_op_t ALU_XOR   = 4'd4;
	localparam alu_op_t ALU_SLT   = 4'd5;
	localparam alu_op_t ALU_PASSB = 4'd6;

	// RV32I major opcodes
	localparam logic [6:0] OP_RTYPE  = 7'b0110011;
	localparam logic [6:0] OP_ITYPE  = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_LUI    = 7'b0110111;

	localparam jump_t JMP_NONE = 2'b00;
	localparam jump_t JMP_JAL  = 2'b01;
	localparam jump_t JMP_JALR = 2'b10;

	localparam word_t PC_RESET_DEFAULT = 32'h0000_0000;

endpackage

`default_nettype wire

// File: verilog/rv_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module rv_reg_file (
	input  wire                    i_clk,
	input  wire rv_pkg::reg_addr_t i_rs1,
	input  wire rv_pkg::reg_addr_t i_rs2,
	input  wire rv_pkg::reg_addr_t i_rd,
	input  wire                    i_wen,
	input  wire rv_pkg::word_t     i_wdata,
	output rv_pkg::word_t          o_rdata1,
	output rv_pkg::word_t          o_rdata2
);

	rv_pkg::word_t regs [0:31];

	// x0 is never written
	always_ff @(posedge i_clk) begin
		if (i_wen && i_rd != 5'd0) begin
			regs[i_rd] <= i_wdata;
		end
	end

	assign o_rdata1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
	assign o_rdata2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire
